//--- src/isa_pkg.sv
// MIPS subset instruction-set constants
// Opcodes, funct codes, data width and instruction field positions

`default_nettype none

package isa_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int op_w       = 6;
	localparam int fn_w       = 6;
	localparam int imm_w      = 16;
	localparam int index_w    = 26;

	// Field positions, low bit of each field
	localparam int op_lsb = 26;
	localparam int rs_lsb = 21;
	localparam int rt_lsb = 16;
	localparam int rd_lsb = 11;
	localparam int fn_lsb = 0;

	// --------------------------------------------------
	// Opcodes
	// --------------------------------------------------
	localparam logic [op_w-1:0] op_rtype = 6'b000000;
	localparam logic [op_w-1:0] op_j     = 6'b000010;
	localparam logic [op_w-1:0] op_beq   = 6'b000100;
	localparam logic [op_w-1:0] op_bne   = 6'b000101;
	localparam logic [op_w-1:0] op_addi  = 6'b001000;
	localparam logic [op_w-1:0] op_addiu = 6'b001001;
	localparam logic [op_w-1:0] op_andi  = 6'b001100;
	localparam logic [op_w-1:0] op_lw    = 6'b100011;
	localparam logic [op_w-1:0] op_sw    = 6'b101011;

	// R-type funct codes
	localparam logic [fn_w-1:0] fn_add = 6'b100000;
	localparam logic [fn_w-1:0] fn_sub = 6'b100010;
	localparam logic [fn_w-1:0] fn_and = 6'b100100;
	localparam logic [fn_w-1:0] fn_or  = 6'b100101;
	localparam logic [fn_w-1:0] fn_slt = 6'b101010;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
// Pipeline control-field layout
// Bit positions of the ex, m and wb fields and the ALU operation codes

`default_nettype none

package pipe_pkg;

	// Field widths
	localparam int ex_w     = 6;
	localparam int m_w      = 2;
	localparam int wb_w     = 2;
	localparam int alu_op_w = 4;

	// ex field, {reg_dst, alu_src, alu_op}
	localparam int ex_bit_reg_dst = 5;
	localparam int ex_bit_alu_src = 4;
	localparam int ex_alu_op_lsb  = 0;

	// m field, {mem_read, mem_write}
	localparam int m_bit_mem_read  = 1;
	localparam int m_bit_mem_write = 0;

	// wb field, {reg_write, mem_to_reg}
	localparam int wb_bit_reg_write  = 1;
	localparam int wb_bit_mem_to_reg = 0;

	// ALU operations
	localparam logic [alu_op_w-1:0] alu_add   = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub   = 4'd1;
	localparam logic [alu_op_w-1:0] alu_and   = 4'd2;
	localparam logic [alu_op_w-1:0] alu_or    = 4'd3;
	localparam logic [alu_op_w-1:0] alu_slt   = 4'd4;
	// Resolved from funct in execute
	localparam logic [alu_op_w-1:0] alu_funct = 4'd15;

endpackage

`default_nettype wire

//--- src/fetch_stage.sv
// Fetch stage
// PC register with next-PC select and the IF/ID register
// Hold freezes both, a redirect loads the target and flushes IF/ID

`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      hold,
	input  wire                      redirect,
	input  wire  [isa_pkg::xlen-1:0] target,
	output logic [isa_pkg::xlen-1:0] imem_addr,
	input  wire  [isa_pkg::xlen-1:0] imem_data,
	output logic [isa_pkg::xlen-1:0] if_inst,
	output logic [isa_pkg::xlen-1:0] if_pc_plus4
);
	import isa_pkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;

	assign pc_plus4  = pc + xlen'(4);
	// ROM reads asynchronously
	assign imem_addr = pc;

	// Redirect wins over hold
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pc <= '0;
		else if (redirect)
			pc <= target;
		else if (!hold)
			pc <= pc_plus4;
	end

	// IF/ID, all-zero word acts as a nop
	always_ff @(posedge clk)
	begin
		if (!rst_n || redirect)
		begin
			if_inst     <= '0;
			if_pc_plus4 <= '0;
		end
		else if (!hold)
		begin
			if_inst     <= imem_data;
			if_pc_plus4 <= pc_plus4;
		end
	end

	// A jump never starts in the same cycle as a stall
	a_jump_no_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!($rose(redirect) && $rose(hold)));

endmodule

`default_nettype wire

//--- src/register_file.sv
// Register file, 32 words of 32 bits
// Two asynchronous read ports, one write port on the clock edge
// Reads of the register being written return the new value

`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  [isa_pkg::reg_addr_w-1:0] rs,
	input  wire  [isa_pkg::reg_addr_w-1:0] rt,
	input  wire                            we,
	input  wire  [isa_pkg::reg_addr_w-1:0] wr_addr,
	input  wire  [isa_pkg::xlen-1:0]       wr_data,
	output logic [isa_pkg::xlen-1:0]       rd_data_1,
	output logic [isa_pkg::xlen-1:0]       rd_data_2
);
	import isa_pkg::*;

	localparam int nregs = 2 ** reg_addr_w;

	logic [xlen-1:0] regs [0:nregs-1];

	// Writes to r0 are dropped
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < nregs; i++)
				regs[i] <= '0;
		end
		else if (we && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

	// --------------------------------------------------
	// Read ports
	// --------------------------------------------------
	// r0 reads zero, same-cycle write bypasses the array
	assign rd_data_1 = (rs == '0) ? '0 :
		(we && wr_addr == rs) ? wr_data : regs[rs];
	assign rd_data_2 = (rt == '0) ? '0 :
		(we && wr_addr == rt) ? wr_data : regs[rt];

	// Writeback data from MEM/WB is always resolved
	a_write_known: assert property (@(posedge clk) disable iff (!rst_n)
		(we && wr_addr != '0) |-> !$isunknown(wr_data));

endmodule

`default_nettype wire

//--- src/control_decoder.sv
// Control decoder
// Maps the opcode onto the ex, m and wb fields plus the jump flags
// Bubble or an unknown opcode yields all-zero fields

`timescale 1ns/1ps
`default_nettype none

module control_decoder (
	input  wire  [isa_pkg::op_w-1:0]  opcode,
	input  wire                       bubble,
	output logic [pipe_pkg::ex_w-1:0] ex,
	output logic [pipe_pkg::m_w-1:0]  m,
	output logic [pipe_pkg::wb_w-1:0] wb,
	output logic                      jump,
	output logic                      branch_ne,
	output logic                      illegal
);
	import isa_pkg::*;
	import pipe_pkg::*;

	always_comb
	begin
		// Bubble unless decoded below
		ex        = '0;
		m         = '0;
		wb        = '0;
		jump      = 1'b0;
		branch_ne = 1'b0;
		illegal   = 1'b0;
		if (!bubble)
		begin
			case (opcode)
				op_rtype:
				begin
					ex[ex_bit_reg_dst]               = 1'b1;
					ex[ex_alu_op_lsb +: alu_op_w]    = alu_funct;
					wb[wb_bit_reg_write]             = 1'b1;
				end
				op_addi, op_addiu:
				begin
					// No overflow trap, both add the same way
					ex[ex_bit_alu_src]               = 1'b1;
					ex[ex_alu_op_lsb +: alu_op_w]    = alu_add;
					wb[wb_bit_reg_write]             = 1'b1;
				end
				op_andi:
				begin
					ex[ex_bit_alu_src]               = 1'b1;
					ex[ex_alu_op_lsb +: alu_op_w]    = alu_and;
					wb[wb_bit_reg_write]             = 1'b1;
				end
				op_lw:
				begin
					ex[ex_bit_alu_src]               = 1'b1;
					ex[ex_alu_op_lsb +: alu_op_w]    = alu_add;
					m[m_bit_mem_read]                = 1'b1;
					wb[wb_bit_reg_write]             = 1'b1;
					wb[wb_bit_mem_to_reg]            = 1'b1;
				end
				op_sw:
				begin
					ex[ex_bit_alu_src]               = 1'b1;
					ex[ex_alu_op_lsb +: alu_op_w]    = alu_add;
					m[m_bit_mem_write]               = 1'b1;
				end
				// Resolved in decode, nothing further down the pipe
				op_beq, op_j:
					jump = 1'b1;
				op_bne:
				begin
					jump      = 1'b1;
					branch_ne = 1'b1;
				end
				default:
					illegal = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
// Decode stage
// Operand fetch, load-use and branch stalls, branch and jump resolution
// Registers control fields and operands into ID/EX

`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  [isa_pkg::xlen-1:0]       if_inst,
	input  wire  [isa_pkg::xlen-1:0]       if_pc_plus4,
	input  wire  [isa_pkg::reg_addr_w-1:0] ex_rt,
	input  wire                            ex_mem_read,
	input  wire  [isa_pkg::reg_addr_w-1:0] ex_dest,
	input  wire  [isa_pkg::reg_addr_w-1:0] mem_dest,
	input  wire                            mem_reg_write,
	input  wire                            wb_reg_write,
	input  wire  [isa_pkg::reg_addr_w-1:0] wb_dest,
	input  wire  [isa_pkg::xlen-1:0]       wb_data,
	output logic                           hold,
	output logic                           redirect,
	output logic [isa_pkg::xlen-1:0]       target,
	output logic [pipe_pkg::ex_w-1:0]      id_ex,
	output logic [pipe_pkg::m_w-1:0]       id_m,
	output logic [pipe_pkg::wb_w-1:0]      id_wb,
	output logic [isa_pkg::xlen-1:0]       id_data_1,
	output logic [isa_pkg::xlen-1:0]       id_data_2,
	output logic [isa_pkg::xlen-1:0]       id_imm,
	output logic [isa_pkg::reg_addr_w-1:0] id_rs,
	output logic [isa_pkg::reg_addr_w-1:0] id_rt,
	output logic [isa_pkg::reg_addr_w-1:0] id_rd,
	output logic [isa_pkg::fn_w-1:0]       id_funct,
	output logic                           exception
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [op_w-1:0]       opcode;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [imm_w-1:0]      imm16;
	logic [xlen-1:0]       imm_ext;
	logic [xlen-1:0]       data_1;
	logic [xlen-1:0]       data_2;
	logic [ex_w-1:0]       ex;
	logic [m_w-1:0]        m;
	logic [wb_w-1:0]       wb;
	logic                  jump;
	logic                  branch_ne;
	logic                  illegal;
	logic                  is_j;
	logic                  is_branch;
	logic                  uses_rt;
	logic                  load_use;
	logic                  branch_stall;

	assign opcode = if_inst[op_lsb +: op_w];
	assign rs     = if_inst[rs_lsb +: reg_addr_w];
	assign rt     = if_inst[rt_lsb +: reg_addr_w];
	assign imm16  = if_inst[imm_w-1:0];

	// andi zero-extends, everything else sign-extends
	assign imm_ext = (opcode == op_andi) ? {{(xlen-imm_w){1'b0}}, imm16} :
		{{(xlen-imm_w){imm16[imm_w-1]}}, imm16};

	register_file u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.rs        (rs),
		.rt        (rt),
		.we        (wb_reg_write),
		.wr_addr   (wb_dest),
		.wr_data   (wb_data),
		.rd_data_1 (data_1),
		.rd_data_2 (data_2)
	);

	control_decoder u_ctrl (
		.opcode    (opcode),
		.bubble    (hold),
		.ex        (ex),
		.m         (m),
		.wb        (wb),
		.jump      (jump),
		.branch_ne (branch_ne),
		.illegal   (illegal)
	);

	// --------------------------------------------------
	// Hazard detection
	// --------------------------------------------------
	assign is_j      = (opcode == op_j);
	assign is_branch = (opcode == op_beq) || (opcode == op_bne);
	assign uses_rt   = (opcode == op_rtype) || is_branch || (opcode == op_sw);

	// Load in EX feeding this instruction
	assign load_use = ex_mem_read && (ex_rt != '0) &&
		((!is_j && ex_rt == rs) || (uses_rt && ex_rt == rt));
	// Branch compares in ID, so wait until the source reaches WB
	assign branch_stall = is_branch &&
		(((ex_dest != '0) && (ex_dest == rs || ex_dest == rt)) ||
		(mem_reg_write && (mem_dest != '0) && (mem_dest == rs || mem_dest == rt)));
	assign hold = load_use || branch_stall;

	// Jump flag is already dropped by the bubble
	assign redirect = jump && (is_j || ((data_1 == data_2) != branch_ne));
	assign target   = is_j ?
		{if_pc_plus4[xlen-1 -: 4], if_inst[index_w-1:0], 2'b00} :
		if_pc_plus4 + {imm_ext[xlen-3:0], 2'b00};

	// ID/EX control, exception pulse registered here too
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			id_ex     <= '0;
			id_m      <= '0;
			id_wb     <= '0;
			exception <= 1'b0;
		end
		else
		begin
			id_ex     <= ex;
			id_m      <= m;
			id_wb     <= wb;
			exception <= illegal;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk)
	begin
		id_data_1 <= data_1;
		id_data_2 <= data_2;
		id_imm    <= imm_ext;
		id_rs     <= rs;
		id_rt     <= rt;
		id_rd     <= if_inst[rd_lsb +: reg_addr_w];
		id_funct  <= if_inst[fn_lsb +: fn_w];
	end

	// Stalled branch never redirects
	a_hold_no_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		!(hold && redirect));

endmodule

`default_nettype wire

//--- src/execute_stage.sv
// Execute stage
// Operand forwarding, immediate select, ALU and destination select
// Results go into the EX/MEM register

`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  [pipe_pkg::ex_w-1:0]      id_ex,
	input  wire  [pipe_pkg::m_w-1:0]       id_m,
	input  wire  [pipe_pkg::wb_w-1:0]      id_wb,
	input  wire  [isa_pkg::xlen-1:0]       id_data_1,
	input  wire  [isa_pkg::xlen-1:0]       id_data_2,
	input  wire  [isa_pkg::xlen-1:0]       id_imm,
	input  wire  [isa_pkg::reg_addr_w-1:0] id_rs,
	input  wire  [isa_pkg::reg_addr_w-1:0] id_rt,
	input  wire  [isa_pkg::reg_addr_w-1:0] id_rd,
	input  wire  [isa_pkg::fn_w-1:0]       id_funct,
	input  wire                            wb_reg_write,
	input  wire  [isa_pkg::reg_addr_w-1:0] wb_dest,
	input  wire  [isa_pkg::xlen-1:0]       wb_data,
	output logic [isa_pkg::reg_addr_w-1:0] ex_rt,
	output logic                           ex_mem_read,
	output logic [isa_pkg::reg_addr_w-1:0] ex_dest,
	output logic [isa_pkg::xlen-1:0]       mem_alu,
	output logic [isa_pkg::xlen-1:0]       mem_store_data,
	output logic [pipe_pkg::m_w-1:0]       mem_m,
	output logic [pipe_pkg::wb_w-1:0]      mem_wb,
	output logic [isa_pkg::reg_addr_w-1:0] mem_dest,
	output logic                           mem_reg_write
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0]       op_a;
	logic [xlen-1:0]       fwd_b;
	logic [xlen-1:0]       op_b;
	logic [xlen-1:0]       alu_y;
	logic [alu_op_w-1:0]   alu_op;
	logic [reg_addr_w-1:0] dest;

	// EX/MEM first, then MEM/WB, r0 never forwarded
	function automatic logic [xlen-1:0] forward(
		input logic [reg_addr_w-1:0] src,
		input logic [xlen-1:0]       reg_val
	);
		if (src != '0 && mem_reg_write && mem_dest == src)
			return mem_alu;
		if (src != '0 && wb_reg_write && wb_dest == src)
			return wb_data;
		return reg_val;
	endfunction

	always_comb
	begin
		op_a  = forward(id_rs, id_data_1);
		fwd_b = forward(id_rt, id_data_2);
	end

	assign op_b = id_ex[ex_bit_alu_src] ? id_imm : fwd_b;
	assign dest = id_ex[ex_bit_reg_dst] ? id_rd : id_rt;

	// --------------------------------------------------
	// ALU
	// --------------------------------------------------
	always_comb
	begin
		alu_op = id_ex[ex_alu_op_lsb +: alu_op_w];
		if (alu_op == alu_funct)
		begin
			case (id_funct)
				fn_sub:  alu_op = alu_sub;
				fn_and:  alu_op = alu_and;
				fn_or:   alu_op = alu_or;
				fn_slt:  alu_op = alu_slt;
				default: alu_op = alu_add;
			endcase
		end
	end

	always_comb
	begin
		case (alu_op)
			alu_sub: alu_y = op_a - op_b;
			alu_and: alu_y = op_a & op_b;
			alu_or:  alu_y = op_a | op_b;
			alu_slt: alu_y = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: alu_y = op_a + op_b;
		endcase
	end

	// Hazard feedback to decode, dest is zero when nothing is written
	assign ex_rt       = id_rt;
	assign ex_mem_read = id_m[m_bit_mem_read];
	assign ex_dest     = id_wb[wb_bit_reg_write] ? dest : '0;

	// EX/MEM
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mem_m  <= '0;
			mem_wb <= '0;
		end
		else
		begin
			mem_m  <= id_m;
			mem_wb <= id_wb;
		end
	end

	always_ff @(posedge clk)
	begin
		mem_alu        <= alu_y;
		mem_store_data <= fwd_b;
		mem_dest       <= dest;
	end

	assign mem_reg_write = mem_wb[wb_bit_reg_write];

endmodule

`default_nettype wire

//--- src/memwb_stage.sv
// Memory and writeback stage
// Drives the data-memory port from EX/MEM and holds MEM/WB
// Writeback picks load data or the ALU result

`timescale 1ns/1ps
`default_nettype none

module memwb_stage (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  [isa_pkg::xlen-1:0]       mem_alu,
	input  wire  [isa_pkg::xlen-1:0]       mem_store_data,
	input  wire  [pipe_pkg::m_w-1:0]       mem_m,
	input  wire  [pipe_pkg::wb_w-1:0]      mem_wb,
	input  wire  [isa_pkg::reg_addr_w-1:0] mem_dest,
	output logic [isa_pkg::xlen-1:0]       dmem_addr,
	output logic [isa_pkg::xlen-1:0]       dmem_wdata,
	output logic                           dmem_we,
	input  wire  [isa_pkg::xlen-1:0]       dmem_rdata,
	output logic                           wb_reg_write,
	output logic [isa_pkg::reg_addr_w-1:0] wb_dest,
	output logic [isa_pkg::xlen-1:0]       wb_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [wb_w-1:0] wb_ctrl;
	logic [xlen-1:0] wb_load;
	logic [xlen-1:0] wb_alu;

	// RAM reads in the same cycle
	assign dmem_addr  = mem_alu;
	assign dmem_wdata = mem_store_data;
	assign dmem_we    = mem_m[m_bit_mem_write];

	// MEM/WB
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb_ctrl <= '0;
		else
			wb_ctrl <= mem_wb;
	end

	always_ff @(posedge clk)
	begin
		wb_load <= dmem_rdata;
		wb_alu  <= mem_alu;
		wb_dest <= mem_dest;
	end

	assign wb_reg_write = wb_ctrl[wb_bit_reg_write];
	assign wb_data      = wb_ctrl[wb_bit_mem_to_reg] ? wb_load : wb_alu;

	// Decoder never marks one op as both load and store
	a_store_not_load: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_we |-> !mem_m[m_bit_mem_read]);

endmodule

`default_nettype wire

//--- src/mips_core.sv
// Five-stage pipelined MIPS subset core
// Fetch, decode, execute and memory/writeback joined by stage wires
// Instruction and data memories sit outside

`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  wire                      clk,
	input  wire                      rst_n,
	output logic [isa_pkg::xlen-1:0] imem_addr,
	input  wire  [isa_pkg::xlen-1:0] imem_data,
	output logic [isa_pkg::xlen-1:0] dmem_addr,
	output logic [isa_pkg::xlen-1:0] dmem_wdata,
	output logic                     dmem_we,
	input  wire  [isa_pkg::xlen-1:0] dmem_rdata,
	output logic                     exception
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Fetch and decode
	logic                  hold;
	logic                  redirect;
	logic [xlen-1:0]       target;
	logic [xlen-1:0]       if_inst;
	logic [xlen-1:0]       if_pc_plus4;

	// ID/EX
	logic [ex_w-1:0]       id_ex;
	logic [m_w-1:0]        id_m;
	logic [wb_w-1:0]       id_wb;
	logic [xlen-1:0]       id_data_1;
	logic [xlen-1:0]       id_data_2;
	logic [xlen-1:0]       id_imm;
	logic [reg_addr_w-1:0] id_rs;
	logic [reg_addr_w-1:0] id_rt;
	logic [reg_addr_w-1:0] id_rd;
	logic [fn_w-1:0]       id_funct;

	// Hazard feedback from EX
	logic [reg_addr_w-1:0] ex_rt;
	logic                  ex_mem_read;
	logic [reg_addr_w-1:0] ex_dest;

	// EX/MEM
	logic [xlen-1:0]       mem_alu;
	logic [xlen-1:0]       mem_store_data;
	logic [m_w-1:0]        mem_m;
	logic [wb_w-1:0]       mem_wb;
	logic [reg_addr_w-1:0] mem_dest;
	logic                  mem_reg_write;

	// Writeback
	logic                  wb_reg_write;
	logic [reg_addr_w-1:0] wb_dest;
	logic [xlen-1:0]       wb_data;

	// Port names match the wires above
	fetch_stage   u_fetch   (.*);
	decode_stage  u_decode  (.*);
	execute_stage u_execute (.*);
	memwb_stage   u_memwb   (.*);

endmodule

`default_nettype wire

//--- bench/tb_memories.sv
// Testbench memories for the core
// Instruction ROM filled word by word from a task
// Data RAM with asynchronous read and a write on the clock edge

`timescale 1ns/1ps
`default_nettype none

module tb_memories (
	input  wire         clk,
	input  wire  [31:0] imem_addr,
	output logic [31:0] imem_data,
	input  wire  [31:0] dmem_addr,
	input  wire  [31:0] dmem_wdata,
	input  wire         dmem_we,
	output logic [31:0] dmem_rdata
);
	logic [31:0] rom [0:63];
	logic [31:0] ram [0:255];

	// Word-addressed with the low two bits ignored
	assign imem_data  = rom[imem_addr[7:2]];
	assign dmem_rdata = ram[dmem_addr[9:2]];

	always @(posedge clk)
	begin
		if (dmem_we)
			ram[dmem_addr[9:2]] <= dmem_wdata;
	end

	// Initial RAM contents hashed from the word index
	function automatic logic [31:0] fill_value(input logic [7:0] idx);
		return ({24'd0, idx} * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
	endfunction

	task automatic fill_ram();
		for (int i = 0; i < 256; i++)
			ram[i] <= fill_value(i[7:0]);
	endtask

	// Unused slots read as nops
	task automatic clear_rom();
		for (int i = 0; i < 64; i++)
			rom[i] = '0;
	endtask

	task automatic load_word(input int idx, input logic [31:0] word);
		rom[idx] = word;
	endtask

endmodule

`default_nettype wire

//--- bench/core_tb.sv
// Testbench for the pipelined MIPS subset core
// Runs four programs against an instruction-level reference model
// Concurrent assertions match every store and every exception pulse

`timescale 1ns/1ps
`default_nettype none

module core_tb;
	import isa_pkg::*;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;
	logic        exception;

	// Expected events from the model
	logic [31:0] st_addr_q [$];
	logic [31:0] st_data_q [$];
	int          exc_left;
	logic        store_pending;
	logic [31:0] head_addr;
	logic [31:0] head_data;

	logic [31:0] prog [$];
	int          errors;
	int          cycles;
	int          limit;
	int          passed;
	int          failed;

	mips_core UUT (.*);

	tb_memories mem (
		.clk        (clk),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_store_match: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_we |-> (store_pending && dmem_addr == head_addr && dmem_wdata == head_data))
	else
	begin
		errors++;
		$display("FAIL %0t: store addr %h data %h, expected addr %h data %h",
			$time, dmem_addr, dmem_wdata, head_addr, head_data);
	end

	a_exception_expected: assert property (@(posedge clk) disable iff (!rst_n)
		exception |-> (exc_left != 0))
	else
	begin
		errors++;
		$display("FAIL %0t: exception pulse with none expected", $time);
	end

	// Fetch restarts from address zero when reset lifts
	a_pc_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (imem_addr == '0))
	else
	begin
		errors++;
		$display("FAIL %0t: fetch address %h after reset, expected 0",
			$time, $sampled(imem_addr));
	end

	task automatic refresh_heads();
		store_pending = (st_addr_q.size() != 0);
		head_addr     = store_pending ? st_addr_q[0] : '0;
		head_data     = store_pending ? st_data_q[0] : '0;
	endtask

	// Consume events as they go by
	always @(posedge clk)
	begin
		if (rst_n && dmem_we && st_addr_q.size() != 0)
		begin
			void'(st_addr_q.pop_front());
			void'(st_data_q.pop_front());
		end
		if (rst_n && exception && exc_left != 0)
			exc_left--;
		refresh_heads();
	end

	// Watchdog
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout: the core did not finish its programs in %0d cycles", limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// --------------------------------------------------
	// Encoders and program helpers
	// --------------------------------------------------
	function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rs, rt, rd);
		return {op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, rt,
		input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] enc_j(input int idx);
		return {op_j, idx[25:0]};
	endfunction

	function automatic logic [15:0] random_imm();
		return 16'($urandom());
	endfunction

	// A jump to itself ends every program
	task automatic emit_halt();
		prog.push_back(enc_j(prog.size()));
	endtask

	// --------------------------------------------------
	// Reference model stepping one instruction at a time
	// --------------------------------------------------
	task automatic run_model();
		logic [31:0] regs [0:31];
		logic [31:0] mram [int];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] res;
		int          idx;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc = '0;
		for (int step = 0; step < 256; step++)
		begin
			w = prog[pc[7:2]];
			if (w == enc_j(pc[7:2]))
				break;
			a    = regs[w[25:21]];
			b    = regs[w[20:16]];
			simm = {{16{w[15]}}, w[15:0]};
			zimm = {16'd0, w[15:0]};
			res  = a + simm;
			idx  = int'(res[9:2]);
			pc   = pc + 4;
			case (w[31:26])
				op_rtype:
				begin
					case (w[5:0])
						fn_sub:  res = a - b;
						fn_and:  res = a & b;
						fn_or:   res = a | b;
						fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: res = a + b;
					endcase
					if (w[15:11] != 0)
						regs[w[15:11]] = res;
				end
				op_addi, op_addiu:
					if (w[20:16] != 0)
						regs[w[20:16]] = a + simm;
				op_andi:
					if (w[20:16] != 0)
						regs[w[20:16]] = a & zimm;
				op_lw:
					if (w[20:16] != 0)
						regs[w[20:16]] = mram.exists(idx) ? mram[idx] : mem.fill_value(idx[7:0]);
				op_sw:
				begin
					mram[idx] = b;
					st_addr_q.push_back(res);
					st_data_q.push_back(b);
				end
				op_beq:
					if (a == b)
						pc = pc + (simm << 2);
				op_bne:
					if (a != b)
						pc = pc + (simm << 2);
				op_j:
					pc = {pc[31:28], w[25:0], 2'b00};
				default:
					exc_left++;
			endcase
		end
	endtask

	// Reset, load, model, then run until every expected event is seen
	task automatic run_program(input string name);
		int errors_before;
		errors_before = errors;
		limit += 64 * prog.size();
		@(negedge clk);
		rst_n = 1'b0;
		mem.fill_ram();
		mem.clear_rom();
		foreach (prog[i])
			mem.load_word(i, prog[i]);
		st_addr_q.delete();
		st_data_q.delete();
		exc_left = 0;
		run_model();
		refresh_heads();
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		while (st_addr_q.size() != 0 || exc_left != 0)
			@(negedge clk);
		// Pipeline drain to catch stray stores after the last one
		repeat (8) @(negedge clk);
		if (errors == errors_before)
		begin
			passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
		prog.delete();
	endtask

	initial
	begin
		rst_n    = 1'b0;
		errors   = 0;
		cycles   = 0;
		limit    = 0;
		passed   = 0;
		failed   = 0;
		exc_left = 0;
		void'($urandom(32'h8d2d_43a5));
		mem.clear_rom();
		mem.fill_ram();
		refresh_heads();

		// Dependent ALU chain through forwarding
		prog.push_back(enc_i(op_addi, 0, 1, random_imm()));
		prog.push_back(enc_i(op_addiu, 1, 2, random_imm()));
		prog.push_back(enc_r(fn_add, 1, 2, 3));
		prog.push_back(enc_i(op_sw, 0, 3, 16'h0000));
		prog.push_back(enc_r(fn_sub, 3, 1, 4));
		prog.push_back(enc_r(fn_and, 4, 2, 5));
		prog.push_back(enc_i(op_sw, 0, 5, 16'h0004));
		prog.push_back(enc_r(fn_or, 5, 3, 6));
		prog.push_back(enc_r(fn_slt, 6, 1, 7));
		prog.push_back(enc_i(op_sw, 0, 7, 16'h0008));
		prog.push_back(enc_i(op_andi, 6, 8, random_imm()));
		prog.push_back(enc_i(op_sw, 0, 8, 16'h000c));
		prog.push_back(enc_i(op_sw, 0, 6, 16'h0010));
		emit_halt();
		run_program("alu_forwarding");

		// Load-use and branch stalls
		prog.push_back(enc_i(op_lw, 0, 1, 16'h0010));
		prog.push_back(enc_r(fn_add, 1, 1, 2));
		prog.push_back(enc_i(op_sw, 0, 2, 16'h0040));
		prog.push_back(enc_i(op_lw, 0, 3, 16'h0014));
		prog.push_back(enc_i(op_sw, 0, 3, 16'h0044));
		prog.push_back(enc_i(op_addi, 0, 4, random_imm()));
		prog.push_back(enc_i(op_beq, 4, 2, 16'd1));
		prog.push_back(enc_i(op_sw, 0, 4, 16'h0048));
		prog.push_back(enc_r(fn_sub, 4, 1, 5));
		prog.push_back(enc_i(op_bne, 5, 0, 16'd1));
		prog.push_back(enc_i(op_sw, 0, 5, 16'h004c));
		prog.push_back(enc_i(op_sw, 0, 1, 16'h0050));
		emit_halt();
		run_program("stalls");

		// Taken and untaken branches, and a jump
		prog.push_back(enc_i(op_addi, 0, 1, random_imm()));
		prog.push_back(enc_i(op_addi, 1, 2, 16'd0));
		prog.push_back(enc_i(op_addi, 1, 3, 16'd1));
		prog.push_back(enc_i(op_beq, 1, 2, 16'd1));
		prog.push_back(enc_i(op_sw, 0, 1, 16'h0080));
		prog.push_back(enc_i(op_bne, 1, 2, 16'd1));
		prog.push_back(enc_i(op_sw, 0, 2, 16'h0084));
		prog.push_back(enc_i(op_bne, 1, 3, 16'd1));
		prog.push_back(enc_i(op_sw, 0, 3, 16'h0088));
		prog.push_back(enc_i(op_beq, 1, 3, 16'd1));
		prog.push_back(enc_i(op_sw, 0, 3, 16'h008c));
		prog.push_back(enc_j(13));
		prog.push_back(enc_i(op_sw, 0, 1, 16'h0090));
		prog.push_back(enc_i(op_sw, 0, 2, 16'h0094));
		emit_halt();
		run_program("branches");

		// Illegal opcode between two stores
		prog.push_back(enc_i(op_addi, 0, 1, random_imm()));
		prog.push_back(enc_i(op_sw, 0, 1, 16'h00a0));
		prog.push_back({6'b111111, 26'($urandom())});
		prog.push_back(enc_i(op_addi, 1, 2, random_imm()));
		prog.push_back(enc_i(op_sw, 0, 2, 16'h00a4));
		emit_halt();
		run_program("illegal_opcode");

		$display("tests passed %0d failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/control_decoder.sv
src/decode_stage.sv
src/execute_stage.sv
src/memwb_stage.sv
src/mips_core.sv
bench/tb_memories.sv
bench/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module core_tb -Mdir obj_dir -o Vcore_tb \
	-f build.f \
	&& ./obj_dir/Vcore_tb | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
